// ==== exu_lite.f ====
+incdir+rtl
rtl/exu_isa_pkg.sv
rtl/exu_pipe_pkg.sv
rtl/exu_ifaces.sv
rtl/exu_decode.sv
rtl/exu_regfile.sv
rtl/exu_disp.sv
rtl/exu_alu.sv
rtl/exu_mul.sv
rtl/exu_wbck.sv
rtl/exu_top.sv
tb/tb_exu_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the exu_lite testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_exu_top \
  -f exu_lite.f -o sim_exu_lite > build.log 2>&1 \
  || { echo "Verilator build error, see build.log"; exit 1; }

./obj_dir/sim_exu_lite > sim.log 2>&1
grep -q "Test failed" sim.log && { echo "Simulation reported a failure, see sim.log"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "No result line in sim.log"; exit 1; }
echo "Simulation passed"

// ==== tb/tb_exu_top.sv ====
`include "exu_defines.svh"

module tb_exu_top;
  import exu_isa_pkg::*;
  import exu_pipe_pkg::*;

  localparam int HS_TIMEOUT    = 50;
  localparam int DRAIN_TIMEOUT = 200;

  logic    i_clk;
  logic    i_rst_n;
  logic    i_valid;
  logic    o_ready;
  instr_u  i_instr;
  logic    o_wbck_valid;
  rf_idx_t o_wbck_rdidx;
  xlen_t   o_wbck_wdat;

  // Architectural state in program order
  xlen_t sw_regs [`EXU_RF_NUM];
  // Expected write data per destination register
  xlen_t exp_q [`EXU_RF_NUM][$];

  logic [15:0] lfsr_q;
  int err_cnt;
  int check_cnt;
  int write_cnt;
  int exp_writes;

  exu_top u_exu_top (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .i_instr      (i_instr),
    .o_wbck_valid (o_wbck_valid),
    .o_wbck_rdidx (o_wbck_rdidx),
    .o_wbck_wdat  (o_wbck_wdat)
  );

  always #10 i_clk = ~i_clk;

  ////////////////////////////////////////
  // Stimulus helpers

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic instr_u enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                   input rf_idx_t rd, input rf_idx_t rs1, input rf_idx_t rs2);
    instr_u ins;
    ins.rtype.funct7 = f7;
    ins.rtype.rs2    = rs2;
    ins.rtype.rs1    = rs1;
    ins.rtype.funct3 = f3;
    ins.rtype.rd     = rd;
    ins.rtype.opcode = OPC_OP;
    return ins;
  endfunction

  function automatic instr_u enc_i(input logic [2:0] f3, input rf_idx_t rd,
                                   input rf_idx_t rs1, input logic [11:0] imm);
    instr_u ins;
    ins.itype.imm12  = imm;
    ins.itype.rs1    = rs1;
    ins.itype.funct3 = f3;
    ins.itype.rd     = rd;
    ins.itype.opcode = OPC_OP_IMM;
    return ins;
  endfunction

  function automatic logic [2:0] pick_f3(input logic [1:0] sel);
    case (sel)
      2'd0:    return F3_ADD;
      2'd1:    return F3_XOR;
      2'd2:    return F3_OR;
      default: return F3_AND;
    endcase
  endfunction

  ////////////////////////////////////////
  // Reference model

  function automatic bit is_legal(input instr_u ins);
    logic [2:0] f3;
    f3 = ins.rtype.funct3;
    if (ins.rtype.opcode == OPC_OP_IMM) begin
      return f3 inside {F3_ADD, F3_XOR, F3_OR, F3_AND};
    end
    if (ins.rtype.opcode == OPC_OP) begin
      if (ins.rtype.funct7 == F7_BASE) return f3 inside {F3_ADD, F3_XOR, F3_OR, F3_AND};
      if (ins.rtype.funct7 == F7_SUB) return f3 == F3_ADD;
      if (ins.rtype.funct7 == F7_MULDIV) return f3 == F3_ADD;
    end
    return 1'b0;
  endfunction

  function automatic xlen_t ref_result(input instr_u ins);
    xlen_t  a;
    xlen_t  b;
    longint prod;
    a = sw_regs[ins.rtype.rs1];
    b = sw_regs[ins.rtype.rs2];
    // I-type second operand is the sign-extended 12-bit field
    if (ins.rtype.opcode == OPC_OP_IMM) begin
      b = xlen_t'(int'($signed(ins.itype.imm12)));
    end else if (ins.rtype.funct7 == F7_MULDIV) begin
      prod = longint'($signed(a)) * longint'($signed(b));
      return prod[31:0];
    end else if (ins.rtype.funct7 == F7_SUB) begin
      return a - b;
    end
    case (ins.rtype.funct3)
      F3_XOR:  return a ^ b;
      F3_OR:   return a | b;
      F3_AND:  return a & b;
      default: return a + b;
    endcase
  endfunction

  ////////////////////////////////////////
  // Checks and run control

  task automatic abort(input string why);
    $display("Run stopped: %s", why);
    $display("Test failed");
    $finish;
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_rdidx(input rf_idx_t got);
    check_cnt++;
    if (got == '0) begin
      err_cnt++;
      $display("ERROR o_wbck_rdidx: got 0x%02h expected nonzero", got);
    end else if (exp_q[got].size() == 0) begin
      err_cnt++;
      $display("Unexpected write to x%0d with no pending result", got);
    end
  endtask

  task automatic check_wdat(input rf_idx_t idx, input xlen_t got, input xlen_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR o_wbck_wdat (x%0d): got 0x%08h expected 0x%08h", idx, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    check_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  function automatic int pending_count();
    int n;
    n = 0;
    for (int r = 0; r < `EXU_RF_NUM; r++) begin
      n += exp_q[r].size();
    end
    return n;
  endfunction

  // Called 2 units after a rising edge, returns at the same phase
  task automatic send_instr(input instr_u ins);
    int    waited;
    xlen_t res;
    i_valid = 1'b1;
    i_instr = ins;
    waited  = 0;
    @(negedge i_clk);
    while (!o_ready && waited < HS_TIMEOUT) begin
      @(negedge i_clk);
      waited++;
    end
    if (!o_ready) abort("instruction handshake never completed");
    // Transfer happens on the coming rising edge
    if (is_legal(ins) && ins.rtype.rd != '0) begin
      res = ref_result(ins);
      sw_regs[ins.rtype.rd] = res;
      exp_q[ins.rtype.rd].push_back(res);
      exp_writes++;
    end
    @(posedge i_clk);
    #2;
    i_valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (pending_count() != 0 && waited < DRAIN_TIMEOUT) begin
      @(negedge i_clk);
      waited++;
    end
    if (pending_count() != 0) abort("write-backs still pending after drain timeout");
    // Longer than the multiplier latency, so stray writes show up
    repeat (4) @(posedge i_clk);
    #2;
  endtask

  task automatic report_case(input int num, input string name, input int errs_before);
    $display("case %0d %-28s %s", num, name, (err_cnt == errs_before) ? "ok" : "mismatch");
  endtask

  task automatic run_random(input int count);
    instr_u     ins;
    logic [2:0] kind;
    logic [2:0] f3;
    rf_idx_t    rd;
    rf_idx_t    rs1;
    rf_idx_t    rs2;
    for (int n = 0; n < count; n++) begin
      kind = 3'(rand_bits(3));
      rd   = rf_idx_t'(rand_bits(5));
      rs1  = rf_idx_t'(rand_bits(5));
      rs2  = rf_idx_t'(rand_bits(5));
      f3   = pick_f3(2'(rand_bits(2)));
      case (kind)
        3'd0, 3'd1: begin
          if (f3 == F3_ADD && rand_bits(1) == 1) ins = enc_r(F7_SUB, f3, rd, rs1, rs2);
          else ins = enc_r(F7_BASE, f3, rd, rs1, rs2);
        end
        3'd2, 3'd3: ins = enc_r(F7_MULDIV, F3_ADD, rd, rs1, rs2);
        3'd7:       ins = enc_r(F7_BASE, 3'b001, rd, rs1, rs2);
        default:    ins = enc_i(f3, rd, rs1, 12'(rand_bits(12)));
      endcase
      send_instr(ins);
      if (rand_bits(2) == 0) begin
        @(posedge i_clk);
        #2;
      end
    end
  endtask

  ////////////////////////////////////////
  // Write-back monitor

  always @(negedge i_clk) begin
    if (i_rst_n && o_wbck_valid) begin
      write_cnt++;
      check_rdidx(o_wbck_rdidx);
      if (o_wbck_rdidx != '0 && exp_q[o_wbck_rdidx].size() != 0) begin
        check_wdat(o_wbck_rdidx, o_wbck_wdat, exp_q[o_wbck_rdidx].pop_front());
      end
    end
  end

  ////////////////////////////////////////
  // Test sequence

  initial begin
    int e0;
    int w0;
    int x0;
    i_clk      = 1'b0;
    i_rst_n    = 1'b0;
    i_valid    = 1'b0;
    i_instr    = '0;
    lfsr_q     = 16'd3;
    err_cnt    = 0;
    check_cnt  = 0;
    write_cnt  = 0;
    exp_writes = 0;
    for (int r = 0; r < `EXU_RF_NUM; r++) begin
      sw_regs[r] = '0;
    end
    repeat (5) @(posedge i_clk);
    #2;
    i_rst_n = 1'b1;

    // 1: idle state out of reset, legal work presented without valid
    e0 = err_cnt;
    i_instr = enc_i(F3_ADD, 5'd1, 5'd0, 12'd1);
    @(negedge i_clk);
    check_bit("o_wbck_valid", o_wbck_valid, 1'b0);
    check_bit("o_ready", o_ready, 1'b1);
    @(posedge i_clk);
    #2;
    i_instr = enc_r(F7_MULDIV, F3_ADD, 5'd1, 5'd1, 5'd1);
    @(negedge i_clk);
    check_bit("o_ready", o_ready, 1'b1);
    @(posedge i_clk);
    #2;
    report_case(1, "reset state", e0);

    // 2: immediates, then register forms
    e0 = err_cnt;
    send_instr(enc_i(F3_ADD, 5'd1, 5'd0, 12'hFFB));
    send_instr(enc_i(F3_ADD, 5'd2, 5'd0, 12'd1234));
    send_instr(enc_i(F3_AND, 5'd3, 5'd1, 12'h0F0));
    send_instr(enc_i(F3_OR,  5'd4, 5'd2, 12'hF00));
    send_instr(enc_i(F3_XOR, 5'd5, 5'd1, 12'h7FF));
    send_instr(enc_i(F3_XOR, 5'd6, 5'd2, 12'hFFF));
    send_instr(enc_r(F7_BASE, F3_ADD, 5'd7,  5'd1, 5'd2));
    send_instr(enc_r(F7_SUB,  F3_ADD, 5'd8,  5'd1, 5'd2));
    send_instr(enc_r(F7_BASE, F3_AND, 5'd9,  5'd4, 5'd5));
    send_instr(enc_r(F7_BASE, F3_OR,  5'd10, 5'd3, 5'd6));
    send_instr(enc_r(F7_BASE, F3_XOR, 5'd11, 5'd7, 5'd8));
    drain();
    report_case(2, "alu immediate and register", e0);

    // 3: multiplier, with ALU work right behind it
    e0 = err_cnt;
    send_instr(enc_i(F3_ADD, 5'd12, 5'd0, 12'hFF9));
    send_instr(enc_i(F3_ADD, 5'd13, 5'd0, 12'h7FF));
    send_instr(enc_r(F7_MULDIV, F3_ADD, 5'd14, 5'd13, 5'd13));
    send_instr(enc_r(F7_MULDIV, F3_ADD, 5'd15, 5'd12, 5'd13));
    send_instr(enc_r(F7_MULDIV, F3_ADD, 5'd16, 5'd14, 5'd14));
    send_instr(enc_r(F7_MULDIV, F3_ADD, 5'd17, 5'd12, 5'd12));
    send_instr(enc_r(F7_MULDIV, F3_ADD, 5'd18, 5'd16, 5'd15));
    send_instr(enc_i(F3_ADD, 5'd19, 5'd1, 12'd100));
    send_instr(enc_i(F3_XOR, 5'd20, 5'd0, 12'hFFF));
    send_instr(enc_r(F7_MULDIV, F3_ADD, 5'd21, 5'd20, 5'd16));
    send_instr(enc_r(F7_BASE, F3_ADD, 5'd22, 5'd2, 5'd2));
    drain();
    report_case(3, "multiply and back-to-back alu", e0);

    // 4: each step reads the previous destination
    e0 = err_cnt;
    send_instr(enc_i(F3_ADD, 5'd25, 5'd0, 12'd3));
    send_instr(enc_r(F7_MULDIV, F3_ADD, 5'd26, 5'd25, 5'd25));
    send_instr(enc_r(F7_BASE, F3_ADD, 5'd27, 5'd26, 5'd25));
    send_instr(enc_r(F7_MULDIV, F3_ADD, 5'd28, 5'd27, 5'd26));
    send_instr(enc_r(F7_SUB, F3_ADD, 5'd29, 5'd28, 5'd27));
    send_instr(enc_i(F3_XOR, 5'd30, 5'd29, 12'hF9C));
    send_instr(enc_r(F7_MULDIV, F3_ADD, 5'd31, 5'd30, 5'd29));
    send_instr(enc_r(F7_BASE, F3_OR, 5'd25, 5'd31, 5'd30));
    send_instr(enc_r(F7_MULDIV, F3_ADD, 5'd25, 5'd25, 5'd25));
    drain();
    report_case(4, "dependent chain", e0);

    // 5: nothing here may reach the write port
    e0 = err_cnt;
    w0 = write_cnt;
    send_instr(enc_r(F7_BASE, F3_ADD, 5'd0, 5'd1, 5'd2));
    send_instr(enc_i(F3_ADD, 5'd0, 5'd1, 12'd5));
    send_instr(enc_r(F7_MULDIV, F3_ADD, 5'd0, 5'd13, 5'd13));
    send_instr(enc_r(F7_BASE, 3'b001, 5'd5, 5'd1, 5'd2));
    send_instr(enc_r(F7_MULDIV, 3'b001, 5'd6, 5'd1, 5'd2));
    send_instr(enc_i(3'b001, 5'd7, 5'd1, 12'd3));
    send_instr(enc_r(F7_SUB, 3'b101, 5'd8, 5'd1, 5'd2));
    send_instr(instr_u'(32'h0000_2283));
    send_instr(instr_u'(32'hFFFF_FFFF));
    drain();
    check_count("write count", write_cnt - w0, 0);
    report_case(5, "rd zero and illegal encodings", e0);

    // 6: random mix of both units
    e0 = err_cnt;
    w0 = write_cnt;
    x0 = exp_writes;
    run_random(200);
    drain();
    check_count("write count", write_cnt - w0, exp_writes - x0);
    report_case(6, "random mix", e0);

    $display("checks %0d, errors %0d, writes %0d", check_cnt, err_cnt, write_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== rtl/exu_top.sv ====
module exu_top (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_valid,
  output logic                  o_ready,
  input  exu_isa_pkg::instr_u   i_instr,
  output logic                  o_wbck_valid,
  output exu_pipe_pkg::rf_idx_t o_wbck_rdidx,
  output exu_pipe_pkg::xlen_t   o_wbck_wdat
);
  import exu_pipe_pkg::*;

  fu_sel_e dec_fu_sel;
  alu_op_e dec_alu_op;
  rf_idx_t dec_rs1idx;
  rf_idx_t dec_rs2idx;
  rf_idx_t dec_rdidx;
  logic    dec_rs2en;
  logic    dec_use_imm;
  xlen_t   dec_imm;
  xlen_t   rf_rs1dat;
  xlen_t   rf_rs2dat;
  logic    rf_wen;
  rf_idx_t rf_wrdidx;
  xlen_t   rf_wdat;

  exu_issue_if alu_issue ();
  exu_issue_if mul_issue ();
  exu_wbck_if  alu_wbck ();
  exu_wbck_if  mul_wbck ();

  exu_decode u_exu_decode (
    .i_instr   (i_instr),
    .o_fu_sel  (dec_fu_sel),
    .o_alu_op  (dec_alu_op),
    .o_rs1idx  (dec_rs1idx),
    .o_rs2idx  (dec_rs2idx),
    .o_rdidx   (dec_rdidx),
    .o_rs2en   (dec_rs2en),
    .o_use_imm (dec_use_imm),
    .o_imm     (dec_imm)
  );

  exu_regfile u_exu_regfile (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_rs1idx (dec_rs1idx),
    .i_rs2idx (dec_rs2idx),
    .o_rs1dat (rf_rs1dat),
    .o_rs2dat (rf_rs2dat),
    .i_wen    (rf_wen),
    .i_wrdidx (rf_wrdidx),
    .i_wdat   (rf_wdat)
  );

  exu_disp u_exu_disp (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_valid   (i_valid),
    .o_ready   (o_ready),
    .i_fu_sel  (dec_fu_sel),
    .i_alu_op  (dec_alu_op),
    .i_rs1idx  (dec_rs1idx),
    .i_rs2idx  (dec_rs2idx),
    .i_rs2en   (dec_rs2en),
    .i_use_imm (dec_use_imm),
    .i_imm     (dec_imm),
    .i_rdidx   (dec_rdidx),
    .i_rs1dat  (rf_rs1dat),
    .i_rs2dat  (rf_rs2dat),
    .i_wen     (rf_wen),
    .i_wrdidx  (rf_wrdidx),
    .alu_issue (alu_issue),
    .mul_issue (mul_issue)
  );

  exu_alu u_exu_alu (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .issue   (alu_issue),
    .wbck    (alu_wbck)
  );

  exu_mul u_exu_mul (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .issue   (mul_issue),
    .wbck    (mul_wbck)
  );

  exu_wbck u_exu_wbck (
    .alu_wbck (alu_wbck),
    .mul_wbck (mul_wbck),
    .o_wen    (rf_wen),
    .o_wrdidx (rf_wrdidx),
    .o_wdat   (rf_wdat)
  );

  // Every register file write is visible outside
  assign o_wbck_valid = rf_wen;
  assign o_wbck_rdidx = rf_wrdidx;
  assign o_wbck_wdat  = rf_wdat;

endmodule

// ==== rtl/exu_wbck.sv ====
module exu_wbck (
  exu_wbck_if.slave              alu_wbck,
  exu_wbck_if.slave              mul_wbck,
  output logic                   o_wen,
  output exu_pipe_pkg::rf_idx_t  o_wrdidx,
  output exu_pipe_pkg::xlen_t    o_wdat
);

  logic mul_grant;
  logic alu_grant;

  ////////////////////////////////////////
  // Fixed priority, multiplier first

  assign mul_grant = mul_wbck.valid;
  assign alu_grant = alu_wbck.valid && !mul_wbck.valid;

  assign mul_wbck.ready = mul_grant;
  assign alu_wbck.ready = alu_grant;

  ////////////////////////////////////////
  // Register file write port

  assign o_wen    = mul_grant || alu_grant;
  assign o_wrdidx = mul_grant ? mul_wbck.rdidx : alu_wbck.rdidx;
  assign o_wdat   = mul_grant ? mul_wbck.wdat  : alu_wbck.wdat;

endmodule

// ==== rtl/exu_mul.sv ====
module exu_mul (
  input  logic       i_clk,
  input  logic       i_rst_n,
  exu_issue_if.slave issue,
  exu_wbck_if.master wbck
);
  import exu_pipe_pkg::*;

  logic    s1_valid_q;
  logic    s2_valid_q;
  xlen_t   s1_op1_q;
  xlen_t   s1_op2_q;
  rf_idx_t s1_rd_q;
  rf_idx_t s2_rd_q;
  xlen_t   s2_dat_q;
  xlen_t   prod_lo;
  logic    stall;

  // Both stages hold while the finished result waits for the arbiter
  assign stall       = s2_valid_q && !wbck.ready;
  assign issue.ready = !stall;

  // Low half only, same for signed and unsigned operands
  assign prod_lo = s1_op1_q * s1_op2_q;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else if (!stall) begin
      s1_valid_q <= issue.valid;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!stall) begin
      if (issue.valid) begin
        s1_op1_q <= issue.op1;
        s1_op2_q <= issue.op2;
        s1_rd_q  <= issue.rd;
      end
      if (s1_valid_q) begin
        s2_dat_q <= prod_lo;
        s2_rd_q  <= s1_rd_q;
      end
    end
  end

  assign wbck.valid = s2_valid_q;
  assign wbck.rdidx = s2_rd_q;
  assign wbck.wdat  = s2_dat_q;

  a_s2_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (wbck.valid && !wbck.ready) |=> ($stable(wbck.wdat) && $stable(wbck.rdidx)));

endmodule

// ==== rtl/exu_alu.sv ====
module exu_alu (
  input  logic       i_clk,
  input  logic       i_rst_n,
  exu_issue_if.slave issue,
  exu_wbck_if.master wbck
);
  import exu_pipe_pkg::*;

  logic    valid_q;
  xlen_t   res_q;
  rf_idx_t rd_q;
  xlen_t   res;

  always_comb begin
    case (issue.alu_op)
      ALU_ADD: res = issue.op1 + issue.op2;
      ALU_SUB: res = issue.op1 - issue.op2;
      ALU_AND: res = issue.op1 & issue.op2;
      ALU_OR:  res = issue.op1 | issue.op2;
      ALU_XOR: res = issue.op1 ^ issue.op2;
      default: res = issue.op1 + issue.op2;
    endcase
  end

  // Take new work when empty or when the held result leaves this cycle
  assign issue.ready = !valid_q || wbck.ready;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (issue.ready) begin
      valid_q <= issue.valid;
    end
  end

  // Result register
  always_ff @(posedge i_clk) begin
    if (issue.valid && issue.ready) begin
      res_q <= res;
      rd_q  <= issue.rd;
    end
  end

  assign wbck.valid = valid_q;
  assign wbck.rdidx = rd_q;
  assign wbck.wdat  = res_q;

endmodule

// ==== rtl/exu_disp.sv ====
`include "exu_defines.svh"

module exu_disp (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_valid,
  output logic                  o_ready,
  input  exu_pipe_pkg::fu_sel_e i_fu_sel,
  input  exu_pipe_pkg::alu_op_e i_alu_op,
  input  exu_pipe_pkg::rf_idx_t i_rs1idx,
  input  exu_pipe_pkg::rf_idx_t i_rs2idx,
  input  logic                  i_rs2en,
  input  logic                  i_use_imm,
  input  exu_pipe_pkg::xlen_t   i_imm,
  input  exu_pipe_pkg::rf_idx_t i_rdidx,
  input  exu_pipe_pkg::xlen_t   i_rs1dat,
  input  exu_pipe_pkg::xlen_t   i_rs2dat,
  input  logic                  i_wen,
  input  exu_pipe_pkg::rf_idx_t i_wrdidx,
  exu_issue_if.master           alu_issue,
  exu_issue_if.master           mul_issue
);
  import exu_pipe_pkg::*;

  logic [`EXU_RF_NUM-1:0] busy_q;
  logic [`EXU_RF_NUM-1:0] busy_d;
  logic discard;
  logic hazard;
  logic to_alu;
  logic to_mul;
  logic issue_fire;
  xlen_t op2;

  ////////////////////////////////////////
  // Scoreboard check

  // Illegal or rd=0 work has no visible effect, so it is dropped here
  assign discard = (i_fu_sel == FU_NONE) || (i_rdidx == '0);
  assign hazard  = busy_q[i_rs1idx] || (i_rs2en && busy_q[i_rs2idx]) || busy_q[i_rdidx];
  assign to_alu  = (i_fu_sel == FU_ALU) && !discard;
  assign to_mul  = (i_fu_sel == FU_MUL) && !discard;

  assign o_ready = discard
                || (to_alu && !hazard && alu_issue.ready)
                || (to_mul && !hazard && mul_issue.ready);

  ////////////////////////////////////////
  // Issue

  assign op2 = i_use_imm ? i_imm : i_rs2dat;

  assign alu_issue.valid  = i_valid && to_alu && !hazard;
  assign alu_issue.alu_op = i_alu_op;
  assign alu_issue.op1    = i_rs1dat;
  assign alu_issue.op2    = op2;
  assign alu_issue.rd     = i_rdidx;

  assign mul_issue.valid  = i_valid && to_mul && !hazard;
  assign mul_issue.alu_op = i_alu_op;
  assign mul_issue.op1    = i_rs1dat;
  assign mul_issue.op2    = op2;
  assign mul_issue.rd     = i_rdidx;

  assign issue_fire = (alu_issue.valid && alu_issue.ready)
                   || (mul_issue.valid && mul_issue.ready);

  always_comb begin
    busy_d = busy_q;
    if (i_wen) begin
      busy_d[i_wrdidx] = 1'b0;
    end
    if (issue_fire) begin
      busy_d[i_rdidx] = 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_d;
    end
  end

  // Issued rd was free and stays marked until its write-back lands
  a_issue_rd_free: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    issue_fire |-> !busy_q[i_rdidx] ##1 busy_q[$past(i_rdidx)]);

endmodule

// ==== rtl/exu_regfile.sv ====
`include "exu_defines.svh"

module exu_regfile (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  exu_pipe_pkg::rf_idx_t i_rs1idx,
  input  exu_pipe_pkg::rf_idx_t i_rs2idx,
  output exu_pipe_pkg::xlen_t   o_rs1dat,
  output exu_pipe_pkg::xlen_t   o_rs2dat,
  input  logic                  i_wen,
  input  exu_pipe_pkg::rf_idx_t i_wrdidx,
  input  exu_pipe_pkg::xlen_t   i_wdat
);
  import exu_pipe_pkg::*;

  // x0 has no storage
  xlen_t rf_q [1:`EXU_RF_NUM-1];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int k = 1; k < `EXU_RF_NUM; k++) begin
        rf_q[k] <= '0;
      end
    end else if (i_wen && (i_wrdidx != '0)) begin
      rf_q[i_wrdidx] <= i_wdat;
    end
  end

  assign o_rs1dat = (i_rs1idx == '0) ? '0 : rf_q[i_rs1idx];
  assign o_rs2dat = (i_rs2idx == '0) ? '0 : rf_q[i_rs2idx];

  // Dispatch never issues rd=0, so the arbiter never writes it
  a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_wen |-> (i_wrdidx != '0));

endmodule

// ==== rtl/exu_decode.sv ====
`include "exu_defines.svh"

module exu_decode (
  input  exu_isa_pkg::instr_u   i_instr,
  output exu_pipe_pkg::fu_sel_e o_fu_sel,
  output exu_pipe_pkg::alu_op_e o_alu_op,
  output exu_pipe_pkg::rf_idx_t o_rs1idx,
  output exu_pipe_pkg::rf_idx_t o_rs2idx,
  output exu_pipe_pkg::rf_idx_t o_rdidx,
  output logic                  o_rs2en,
  output logic                  o_use_imm,
  output exu_pipe_pkg::xlen_t   o_imm
);
  import exu_isa_pkg::*;
  import exu_pipe_pkg::*;

  // Register fields sit at the same bits in both views
  assign o_rs1idx = i_instr.rtype.rs1;
  assign o_rs2idx = i_instr.rtype.rs2;
  assign o_rdidx  = i_instr.rtype.rd;

  assign o_imm = {{(`EXU_XLEN-12){i_instr.itype.imm12[11]}}, i_instr.itype.imm12};

  always_comb begin
    o_fu_sel  = FU_NONE;
    o_alu_op  = ALU_ADD;
    o_rs2en   = 1'b0;
    o_use_imm = 1'b0;
    case (i_instr.rtype.opcode)
      OPC_OP: begin
        o_rs2en = 1'b1;
        case (i_instr.rtype.funct7)
          F7_BASE: begin
            o_fu_sel = FU_ALU;
            case (i_instr.rtype.funct3)
              F3_ADD:  o_alu_op = ALU_ADD;
              F3_XOR:  o_alu_op = ALU_XOR;
              F3_OR:   o_alu_op = ALU_OR;
              F3_AND:  o_alu_op = ALU_AND;
              default: o_fu_sel = FU_NONE;
            endcase
          end
          F7_SUB: begin
            o_alu_op = ALU_SUB;
            o_fu_sel = (i_instr.rtype.funct3 == F3_ADD) ? FU_ALU : FU_NONE;
          end
          // MUL only, the rest of M is not supported
          F7_MULDIV: o_fu_sel = (i_instr.rtype.funct3 == F3_ADD) ? FU_MUL : FU_NONE;
          default:   o_fu_sel = FU_NONE;
        endcase
      end
      OPC_OP_IMM: begin
        o_use_imm = 1'b1;
        o_fu_sel  = FU_ALU;
        case (i_instr.itype.funct3)
          F3_ADD:  o_alu_op = ALU_ADD;
          F3_XOR:  o_alu_op = ALU_XOR;
          F3_OR:   o_alu_op = ALU_OR;
          F3_AND:  o_alu_op = ALU_AND;
          default: o_fu_sel = FU_NONE;
        endcase
      end
      default: o_fu_sel = FU_NONE;
    endcase
  end

endmodule

// ==== rtl/exu_ifaces.sv ====
// Dispatch to functional unit
interface exu_issue_if;
  import exu_pipe_pkg::*;

  logic    valid;
  logic    ready;
  alu_op_e alu_op;
  xlen_t   op1;
  xlen_t   op2;
  rf_idx_t rd;

  modport master (output valid, output alu_op, output op1, output op2, output rd,
                  input ready);
  modport slave  (input valid, input alu_op, input op1, input op2, input rd,
                  output ready);
endinterface

// Functional unit result to write-back arbiter
interface exu_wbck_if;
  import exu_pipe_pkg::*;

  logic    valid;
  logic    ready;
  rf_idx_t rdidx;
  xlen_t   wdat;

  modport master (output valid, output rdidx, output wdat, input ready);
  modport slave  (input valid, input rdidx, input wdat, output ready);
endinterface

// ==== rtl/exu_pipe_pkg.sv ====
`include "exu_defines.svh"

package exu_pipe_pkg;

  typedef logic [`EXU_XLEN-1:0]    xlen_t;
  typedef logic [`EXU_RFIDX_W-1:0] rf_idx_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

  // FU_NONE marks an illegal encoding
  typedef enum logic [1:0] {
    FU_NONE,
    FU_ALU,
    FU_MUL
  } fu_sel_e;

endpackage

// ==== rtl/exu_isa_pkg.sv ====
package exu_isa_pkg;

  ////////////////////////////////////////
  // Instruction field layouts

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // Same 32-bit word seen as R-type or I-type
  typedef union packed {
    r_type_t rtype;
    i_type_t itype;
  } instr_u;

  ////////////////////////////////////////
  // Encodings

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_SUB    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage

// ==== rtl/exu_defines.svh ====
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// Datapath width
`define EXU_XLEN 32

// Register index width and register count
`define EXU_RFIDX_W 5
`define EXU_RF_NUM 32

`endif
